// ==== bench/mdu_tb.sv ====
// table-driven testbench for the multiply/divide unit; run mdu_tb as top with the mdu_top.f file list
`timescale 1ns/1ns
`default_nettype none

module mdu_tb import mdu_pkg::*; ();

    localparam logic [31:0] SEED       = 32'he183_27bb;
    localparam logic [31:0] STALL_DATA = 32'hdead_beef;  // operand of the request sent while busy
    localparam int          RAND_ROWS  = 8;

    typedef struct packed {
        mdu_op_e             op;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
        logic                flush;
        logic                stall;
        logic [DATA_W-1:0]   exp_hi;
        logic [DATA_W-1:0]   exp_lo;
    } row_t;

    logic               clk;
    logic               rst_n;
    mdu_req_t           req;
    logic               read_hi;
    logic               flush;
    logic [DATA_W-1:0]  rd_data;
    logic               ready;

    row_t               rows[$];
    logic [DATA_W-1:0]  model_hi;
    logic [DATA_W-1:0]  model_lo;
    mdu_op_e            long_ops[4] = '{OP_MULT, OP_MULTU, OP_DIV, OP_DIVU};
    int                 errors;
    int                 checks;
    int                 cycles;
    int                 cycle_limit;

    mdu_top dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .read_hi (read_hi),
        .flush   (flush),
        .rd_data (rd_data),
        .ready   (ready)
    );

    always #2 clk = ~clk;

    // run limit, sized from the table length
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: no completion after %0d cycles, ready never returned high", cycles);
            $display("summary: %0d checks, %0d errors before the timeout", checks, errors);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // reference model from the arithmetic rules, tracks HI/LO across rows
    task automatic add_row(input mdu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic fl, input logic st);
        row_t             r;
        longint           sa;
        longint           sb;
        longint unsigned  ua;
        longint unsigned  ub;
        logic [63:0]      prod;
        sa = $signed(a);
        sb = $signed(b);
        ua = a;
        ub = b;
        if (!fl || op == OP_MTHI || op == OP_MTLO)  // flush only cancels mult/div
        begin
            case (op)
                OP_MTHI:  model_hi = a;
                OP_MTLO:  model_lo = a;
                OP_MULT:
                begin
                    prod = sa * sb;
                    {model_hi, model_lo} = prod;
                end
                OP_MULTU:
                begin
                    prod = ua * ub;
                    {model_hi, model_lo} = prod;
                end
                OP_DIV, OP_DIVU:
                begin
                    if (b == '0)
                    begin
                        model_hi = a;  // divide by zero rule
                        model_lo = '1;
                    end
                    else if (op == OP_DIV)
                    begin
                        model_lo = 32'(sa / sb);  // truncates toward zero
                        model_hi = 32'(sa % sb);
                    end
                    else
                    begin
                        model_lo = 32'(ua / ub);
                        model_hi = 32'(ua % ub);
                    end
                end
                default: ;
            endcase
        end
        r = '{op: op, a: a, b: b, flush: fl, stall: st, exp_hi: model_hi, exp_lo: model_lo};
        rows.push_back(r);
    endtask

    task automatic wait_ready();
        @(negedge clk);
        while (!ready)
            @(negedge clk);
    endtask

    // one accepted cycle, then an optional flush or a second request that must be ignored
    task automatic run_row(input row_t r);
        mdu_req_t  late_req;
        logic      is_move;
        late_req = '{op: OP_MTHI, a: STALL_DATA, b: ~r.b};
        if (r.op == OP_DIV || r.op == OP_DIVU)
            late_req.op = OP_DIVU;  // a restart would replace the pending quotient
        is_move = (r.op == OP_MTHI) || (r.op == OP_MTLO);
        wait_ready();
        @(posedge clk);
        req <= '{op: r.op, a: r.a, b: r.b};
        @(posedge clk);
        if (r.stall)
            req <= late_req;
        else
            req <= '{op: OP_NONE, a: '0, b: '0};
        flush <= r.flush;
        @(negedge clk);
        compare_value("ready after accept", {31'b0, ready}, {31'b0, is_move});
        @(posedge clk);
        flush <= 1'b0;
        @(posedge clk);  // multiply still busy, a late move would land after its writeback
        req <= '{op: OP_NONE, a: '0, b: '0};
        wait_ready();
    endtask

    task automatic read_and_check(input string tag, input logic [31:0] exp_hi,
                                  input logic [31:0] exp_lo);
        @(posedge clk);
        read_hi <= 1'b1;
        @(negedge clk);
        compare_value({tag, " HI"}, rd_data, exp_hi);
        @(posedge clk);
        read_hi <= 1'b0;
        @(negedge clk);
        compare_value({tag, " LO"}, rd_data, exp_lo);
    endtask

    initial
    begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        req         = '{op: OP_NONE, a: '0, b: '0};
        read_hi     = 1'b0;
        flush       = 1'b0;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        cycle_limit = 0;
        model_hi    = '0;
        model_lo    = '0;
        void'($urandom(SEED));

        // moves
        add_row(OP_MTHI, 32'h1234_5678, 32'h0, 1'b0, 1'b0);
        add_row(OP_MTLO, 32'h9abc_def0, 32'h0, 1'b0, 1'b0);
        add_row(OP_MTHI, 32'h0f0f_0f0f, 32'h0, 1'b0, 1'b0);
        // multiply corners
        add_row(OP_MULT,  32'hffff_fffd, 32'hffff_fffb, 1'b0, 1'b0);  // -3 * -5
        add_row(OP_MULT,  32'h8000_0000, 32'h8000_0000, 1'b0, 1'b0);
        add_row(OP_MULT,  32'h8000_0000, 32'h0000_0001, 1'b0, 1'b0);
        add_row(OP_MULTU, 32'hffff_ffff, 32'hffff_ffff, 1'b0, 1'b0);
        add_row(OP_MULT,  32'hffff_fff9, 32'h0000_0006, 1'b0, 1'b0);
        // divide corners
        add_row(OP_DIV,  32'hffff_fff9, 32'h0000_0002, 1'b0, 1'b0);  // -7 / 2
        add_row(OP_DIV,  32'h0000_0007, 32'hffff_fffe, 1'b0, 1'b0);
        add_row(OP_DIVU, 32'hffff_ffff, 32'h0000_0003, 1'b0, 1'b0);
        add_row(OP_DIV,  32'h8000_0000, 32'hffff_ffff, 1'b0, 1'b0);
        add_row(OP_DIV,  32'h0000_0005, 32'h0000_0000, 1'b0, 1'b0);
        add_row(OP_DIVU, 32'h8000_0000, 32'h0000_0000, 1'b0, 1'b0);
        // flushed in flight, then a second request while busy
        add_row(OP_MULT, 32'h0000_1111, 32'h0000_2222, 1'b1, 1'b0);
        add_row(OP_DIV,  32'h7654_3210, 32'h0000_0013, 1'b1, 1'b0);
        add_row(OP_MULTU, 32'h0001_0003, 32'h0002_0005, 1'b0, 1'b1);
        add_row(OP_DIVU,  32'h7fff_ffff, 32'h0000_1000, 1'b0, 1'b1);
        for (int i = 0; i < RAND_ROWS; i++)
            add_row(long_ops[$urandom % 4], $urandom, $urandom, 1'b0, 1'b0);

        cycle_limit = rows.size() * (DIV_CYCLES + 10) + 100;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        compare_value("ready after reset", {31'b0, ready}, 32'd1);
        read_and_check("after reset", 32'h0, 32'h0);

        foreach (rows[i])
        begin
            run_row(rows[i]);
            read_and_check($sformatf("row %0d (%s)", i, rows[i].op.name()),
                           rows[i].exp_hi, rows[i].exp_lo);
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/mdu_ctrl.sv ====
// request acceptance, busy tracking and hi/lo writeback selection; sits between core and datapaths
`timescale 1ns/1ns
`default_nettype none

module mdu_ctrl import mdu_pkg::*; (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  wire mdu_req_t     req,
    input  wire logic         flush,
    input  wire mdu_result_t  mult_res,
    input  wire mdu_result_t  div_res,
    input  wire logic         div_done,
    output logic              mult_start,
    output logic              div_start,
    output logic              is_signed,
    output hilo_wr_t          hilo_wr,
    output logic              ready
);

    mdu_state_e              state;
    logic [MULT_CNT_W-1:0]   mult_cnt;   // cycles left until product lands
    logic                    go;         // accepted and not flushed
    logic                    is_mult;
    logic                    is_div;

    // pending move, written one edge after acceptance
    logic                    mv_wen_hi;
    logic                    mv_wen_lo;
    logic [DATA_W-1:0]       mv_data;

    assign ready   = (state == ST_IDLE);
    assign go      = ready && (req.op != OP_NONE) && !flush;
    assign is_mult = (req.op == OP_MULT) || (req.op == OP_MULTU);
    assign is_div  = (req.op == OP_DIV) || (req.op == OP_DIVU);

    assign mult_start = go && is_mult;
    assign div_start  = go && is_div;
    assign is_signed  = (req.op == OP_MULT) || (req.op == OP_DIV);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= ST_IDLE;
            mult_cnt <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (mult_start)
                    begin
                        state    <= ST_MULT;
                        mult_cnt <= MULT_CNT_W'(MULT_STAGES - 1);
                    end
                    else if (div_start)
                        state <= ST_DIV;
                end
                ST_MULT:
                begin
                    if (flush || mult_cnt == '0)
                        state <= ST_IDLE;
                    else
                        mult_cnt <= mult_cnt - 1'b1;
                end
                ST_DIV:
                begin
                    if (flush || div_done)
                        state <= ST_IDLE;  // divider may still run after a flush
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mv_wen_hi <= 1'b0;
            mv_wen_lo <= 1'b0;
        end
        else
        begin
            mv_wen_hi <= go && (req.op == OP_MTHI);
            mv_wen_lo <= go && (req.op == OP_MTLO);
        end
    end

    always_ff @(posedge clk)
    begin
        mv_data <= req.a;
    end

    // moves and completions never overlap, a move only follows an idle cycle
    always_comb
    begin
        hilo_wr = '{wen_hi: mv_wen_hi, wen_lo: mv_wen_lo, hi: mv_data, lo: mv_data};
        if (state == ST_MULT && mult_cnt == '0 && !flush)
            hilo_wr = '{wen_hi: 1'b1, wen_lo: 1'b1, hi: mult_res.hi, lo: mult_res.lo};
        else if (state == ST_DIV && div_done && !flush)
            hilo_wr = '{wen_hi: 1'b1, wen_lo: 1'b1, hi: div_res.hi, lo: div_res.lo};
    end

endmodule

`default_nettype wire

// ==== hw/mdu_div.sv ====
// iterative radix-2 restoring divider with sign fix-up; done pulses one cycle with result valid
`timescale 1ns/1ns
`default_nettype none

module mdu_div import mdu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               is_signed,
    input  wire logic [DATA_W-1:0]  a,
    input  wire logic [DATA_W-1:0]  b,
    output mdu_result_t             res,
    output logic                    done
);

    logic                    busy;
    logic [DIV_CNT_W-1:0]    cnt;
    logic                    last_step;

    logic [DATA_W-1:0]       rem;
    logic [DATA_W-1:0]       quo;    // shifts out dividend, shifts in quotient
    logic [DATA_W-1:0]       dvsr;
    logic [DATA_W-1:0]       a_q;    // original dividend for divide by zero
    logic                    q_neg;
    logic                    r_neg;
    logic                    b_zero;

    logic [DATA_W-1:0]       a_mag;
    logic [DATA_W-1:0]       b_mag;
    logic [DATA_W:0]         rem_shift;
    logic [DATA_W+1:0]       diff;
    logic                    fits;
    logic [DATA_W-1:0]       quo_fix;
    logic [DATA_W-1:0]       rem_fix;

    // magnitudes; -(-2^31) still fits unsigned
    assign a_mag = (is_signed && a[DATA_W-1]) ? -a : a;
    assign b_mag = (is_signed && b[DATA_W-1]) ? -b : b;

    assign rem_shift = {rem, quo[DATA_W-1]};
    assign diff      = {1'b0, rem_shift} - {2'b00, dvsr};
    assign fits      = !diff[DATA_W+1];  // no borrow, keep the difference
    assign last_step = (cnt == DIV_CNT_W'(DIV_CYCLES - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end
        else if (start)
        begin
            busy <= 1'b1;  // a new start restarts any run in progress
            cnt  <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= busy && last_step;
            if (busy)
            begin
                cnt <= cnt + 1'b1;
                if (last_step)
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem    <= '0;
            quo    <= a_mag;
            dvsr   <= b_mag;
            a_q    <= a;
            q_neg  <= is_signed && (a[DATA_W-1] ^ b[DATA_W-1]);
            r_neg  <= is_signed && a[DATA_W-1];
            b_zero <= (b == '0);
        end
        else if (busy)
        begin
            rem <= fits ? diff[DATA_W-1:0] : rem_shift[DATA_W-1:0];
            quo <= {quo[DATA_W-2:0], fits};
        end
    end

    // sign fix-up, remainder follows the dividend
    assign quo_fix = q_neg ? -quo : quo;
    assign rem_fix = r_neg ? -rem : rem;

    always_comb
    begin
        if (b_zero)
        begin
            res.hi = a_q;
            res.lo = '1;
        end
        else
        begin
            res.hi = rem_fix;
            res.lo = quo_fix;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mdu_hilo.sv ====
// HI/LO architectural registers with independent write enables and a combinational read select
`timescale 1ns/1ns
`default_nettype none

module mdu_hilo import mdu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire hilo_wr_t           wr,
    input  wire logic               read_hi,
    output logic [DATA_W-1:0]       rd_data
);

    logic [DATA_W-1:0] hi_q;
    logic [DATA_W-1:0] lo_q;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            hi_q <= '0;
            lo_q <= '0;
        end
        else
        begin
            if (wr.wen_hi)
                hi_q <= wr.hi;
            if (wr.wen_lo)
                lo_q <= wr.lo;
        end
    end

    assign rd_data = read_hi ? hi_q : lo_q;  // no bypass of a same-cycle write

endmodule

`default_nettype wire

// ==== hw/mdu_mult.sv ====
// two-stage signed/unsigned 32x32 multiplier; operands captured on start, product two cycles later
`timescale 1ns/1ns
`default_nettype none

module mdu_mult import mdu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               start,
    input  wire logic               is_signed,
    input  wire logic [DATA_W-1:0]  a,
    input  wire logic [DATA_W-1:0]  b,
    output mdu_result_t             res
);

    logic                      s1_vld;
    logic signed [DATA_W:0]    s1_a;   // sign or zero extended
    logic signed [DATA_W:0]    s1_b;
    logic signed [2*DATA_W+1:0] prod;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            s1_vld <= 1'b0;
        else
            s1_vld <= start;
    end

    // stage one
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            s1_a <= {is_signed & a[DATA_W-1], a};
            s1_b <= {is_signed & b[DATA_W-1], b};
        end
    end

    // 33x33 signed covers both flavours
    assign prod = s1_a * s1_b;

    // stage two
    always_ff @(posedge clk)
    begin
        if (s1_vld)
        begin
            res.hi <= prod[2*DATA_W-1:DATA_W];
            res.lo <= prod[DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== hw/mdu_pkg.sv ====
// shared widths, opcode and state enums, and request/writeback structs for the multiply/divide unit
`default_nettype none

package mdu_pkg;

    localparam int DATA_W      = 32;
    localparam int DIV_CYCLES  = 32;  // one quotient bit per cycle
    localparam int MULT_STAGES = 2;

    // counter widths derived from the latencies above
    localparam int DIV_CNT_W  = $clog2(DIV_CYCLES);
    localparam int MULT_CNT_W = (MULT_STAGES > 1) ? $clog2(MULT_STAGES) : 1;

    // core-side opcodes, OP_NONE means no request this cycle
    typedef enum logic [2:0] {
        OP_NONE  = 3'd0,
        OP_MULT  = 3'd1,
        OP_MULTU = 3'd2,
        OP_DIV   = 3'd3,
        OP_DIVU  = 3'd4,
        OP_MTHI  = 3'd5,
        OP_MTLO  = 3'd6
    } mdu_op_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_MULT = 2'd1,  // waiting on multiplier pipe
        ST_DIV  = 2'd2   // waiting on div_done
    } mdu_state_e;

    typedef struct packed {
        mdu_op_e             op;
        logic [DATA_W-1:0]   a;
        logic [DATA_W-1:0]   b;
    } mdu_req_t;

    // one write into the hi/lo pair
    typedef struct packed {
        logic                wen_hi;
        logic                wen_lo;
        logic [DATA_W-1:0]   hi;
        logic [DATA_W-1:0]   lo;
    } hilo_wr_t;

    // multiplier: product halves
    // divider: remainder in hi, quotient in lo
    typedef struct packed {
        logic [DATA_W-1:0]   hi;
        logic [DATA_W-1:0]   lo;
    } mdu_result_t;

endpackage

`default_nettype wire

// ==== hw/mdu_top.sv ====
// multiply/divide unit top level; wires control, multiplier, divider and hi/lo file to the core
`timescale 1ns/1ns
`default_nettype none

module mdu_top import mdu_pkg::*; (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire mdu_req_t           req,
    input  wire logic               read_hi,
    input  wire logic               flush,
    output logic [DATA_W-1:0]       rd_data,
    output logic                    ready
);

    logic         mult_start;
    logic         div_start;
    logic         is_signed;
    logic         div_done;
    mdu_result_t  mult_res;
    mdu_result_t  div_res;
    hilo_wr_t     hilo_wr;

    mdu_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .flush      (flush),
        .mult_res   (mult_res),
        .div_res    (div_res),
        .div_done   (div_done),
        .mult_start (mult_start),
        .div_start  (div_start),
        .is_signed  (is_signed),
        .hilo_wr    (hilo_wr),
        .ready      (ready)
    );

    // operands go straight from the core, captured on the start pulse
    mdu_mult u_mult (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (mult_start),
        .is_signed  (is_signed),
        .a          (req.a),
        .b          (req.b),
        .res        (mult_res)
    );

    mdu_div u_div (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (div_start),
        .is_signed  (is_signed),
        .a          (req.a),
        .b          (req.b),
        .res        (div_res),
        .done       (div_done)
    );

    mdu_hilo u_hilo (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr         (hilo_wr),
        .read_hi    (read_hi),
        .rd_data    (rd_data)
    );

endmodule

`default_nettype wire

// ==== mdu_top.f ====
hw/mdu_pkg.sv
hw/mdu_ctrl.sv
hw/mdu_mult.sv
hw/mdu_div.sv
hw/mdu_hilo.sv
hw/mdu_top.sv
bench/mdu_tb.sv
